// File: hdl/mosfet_eval.sv
/*
 * One transistor, drain current or transconductance scaled by W.
 * Worst case is W = 7 with Vov = 6 in saturation, 252, so the value fits 8 bits.
 */
module mosfet_eval (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  smc_pkg::param_t   w,
    input  smc_pkg::param_t   vgs,
    input  smc_pkg::param_t   vds,
    input  logic              current_mode,
    output logic              out_valid,
    output smc_pkg::dev_val_t value
);

    smc_pkg::param_t   vov;
    logic              triode;
    logic [5:0]        vov_x;
    logic [5:0]        vds_x;
    logic [5:0]        id_unit;
    logic [5:0]        gm_unit;
    logic [5:0]        unit_val;
    smc_pkg::dev_val_t scaled;

    // Overdrive, floored at zero below threshold
    assign vov = (vgs > smc_pkg::param_t'(smc_pkg::vth))
                 ? vgs - smc_pkg::param_t'(smc_pkg::vth)
                 : '0;

    assign triode = (vov > vds);

    assign vov_x = 6'(vov);
    assign vds_x = 6'(vds);

    // Per unit width, at most 36
    assign id_unit = triode ? vds_x * ((vov_x << 1) - vds_x)
                            : vov_x * vov_x;

    // 2 * min(Vov, Vds)
    assign gm_unit = (triode ? vds_x : vov_x) << 1;

    assign unit_val = current_mode ? id_unit : gm_unit;
    assign scaled   = smc_pkg::dev_val_t'(w) * smc_pkg::dev_val_t'(unit_val);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            value <= scaled;
        end
    end

endmodule

// File: hdl/result_combine.sv
/*
 * Thirds of the three selected values, then weighted or plain sum over three.
 * Current mode weights are 3/4 on hi and 5/4 on lo, floored before adding mid.
 */
module result_combine (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic              current_mode,
    input  smc_pkg::dev_val_t hi,
    input  smc_pkg::dev_val_t mid,
    input  smc_pkg::dev_val_t lo,
    output logic              res_valid,
    output smc_pkg::result_t  result
);

    smc_pkg::third_t n_hi;
    smc_pkg::third_t n_mid;
    smc_pkg::third_t n_lo;
    logic [9:0]      weighted;
    logic [9:0]      total;
    logic [9:0]      quotient;

    assign n_hi  = smc_pkg::third_t'(hi / 8'd3);
    assign n_mid = smc_pkg::third_t'(mid / 8'd3);
    assign n_lo  = smc_pkg::third_t'(lo / 8'd3);

    assign weighted = ((10'd3 * 10'(n_hi)) + (10'd5 * 10'(n_lo))) >> 2;

    assign total = current_mode ? weighted + 10'(n_mid)
                                : 10'(n_hi) + 10'(n_mid) + 10'(n_lo);

    assign quotient = total / 10'd3;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            result <= smc_pkg::result_t'(quotient);
        end
    end

    // 255 / 3 bounds every path through the pipeline
    a_result_range: assert property (
        @(posedge clk) disable iff (rst) res_valid |-> (result <= smc_pkg::result_t'(85))
    );

endmodule

// File: hdl/smc_apb_regs.sv
/*
 * APB slave with zero wait states; pready is tied high.
 * Unmapped offsets answer with pslverr, writes to them are dropped.
 * Result register keeps the newest result, there is no back-pressure.
 */
module smc_apb_regs (
    input  logic               clk,
    input  logic               rst,
    input  smc_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  smc_pkg::apb_data_t pwdata,
    output smc_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output smc_pkg::param_t    w   [smc_pkg::num_dev],
    output smc_pkg::param_t    vgs [smc_pkg::num_dev],
    output smc_pkg::param_t    vds [smc_pkg::num_dev],
    output smc_pkg::mode_t     mode,
    output logic               launch,
    input  logic               res_valid,
    input  smc_pkg::result_t   result
);

    logic                        access;
    logic                        wr_en;
    logic                        ctrl_sel;
    logic                        status_sel;
    logic                        result_sel;
    logic [smc_pkg::num_dev-1:0] dev_sel;
    logic                        mapped;
    logic                        done;
    smc_pkg::result_t            result_q;

    // ####################
    // Decode
    // ####################

    always_comb begin
        for (int i = 0; i < smc_pkg::num_dev; i++) begin
            dev_sel[i] = (paddr == smc_pkg::apb_addr_t'(smc_pkg::dev_base_addr
                                                        + i * smc_pkg::dev_stride));
        end
    end

    assign ctrl_sel   = (paddr == smc_pkg::ctrl_addr);
    assign status_sel = (paddr == smc_pkg::status_addr);
    assign result_sel = (paddr == smc_pkg::result_addr);
    assign mapped     = ctrl_sel | status_sel | result_sel | (|dev_sel);

    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    // ####################
    // Configuration
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= '0;
            for (int i = 0; i < smc_pkg::num_dev; i++) begin
                w[i]   <= '0;
                vgs[i] <= '0;
                vds[i] <= '0;
            end
        end else if (wr_en) begin
            if (ctrl_sel) begin
                mode <= pwdata[smc_pkg::ctrl_mode_lsb +: smc_pkg::mode_w];
            end
            for (int i = 0; i < smc_pkg::num_dev; i++) begin
                if (dev_sel[i]) begin
                    w[i]   <= pwdata[smc_pkg::dev_w_lsb +: smc_pkg::param_w];
                    vgs[i] <= pwdata[smc_pkg::dev_vgs_lsb +: smc_pkg::param_w];
                    vds[i] <= pwdata[smc_pkg::dev_vds_lsb +: smc_pkg::param_w];
                end
            end
        end
    end

    // Launch one cycle after the start write, new launch wins over res_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            launch   <= 1'b0;
            done     <= 1'b0;
            result_q <= '0;
        end else begin
            launch <= wr_en & ctrl_sel & pwdata[smc_pkg::ctrl_start_bit];
            if (launch) begin
                done <= 1'b0;
            end else if (res_valid) begin
                done <= 1'b1;
            end
            if (res_valid) begin
                result_q <= result;
            end
        end
    end

    // ####################
    // Read data
    // ####################

    always_comb begin
        prdata = '0;
        if (ctrl_sel) begin
            prdata[smc_pkg::ctrl_mode_lsb +: smc_pkg::mode_w] = mode;
        end
        if (status_sel) begin
            prdata[smc_pkg::status_done_bit] = done;
        end
        if (result_sel) begin
            prdata[smc_pkg::result_w-1:0] = result_q;
        end
        for (int i = 0; i < smc_pkg::num_dev; i++) begin
            if (dev_sel[i]) begin
                prdata[smc_pkg::dev_w_lsb +: smc_pkg::param_w]   = w[i];
                prdata[smc_pkg::dev_vgs_lsb +: smc_pkg::param_w] = vgs[i];
                prdata[smc_pkg::dev_vds_lsb +: smc_pkg::param_w] = vds[i];
            end
        end
    end

    // Access phase is always preceded by a selected setup phase
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst) penable |-> psel
    );

endmodule

// File: hdl/smc_pkg.sv
/*
 * Widths, vector types and APB register map of the MOSFET calculator.
 * All voltages and widths are unsigned 3-bit integers; threshold fixed at vth.
 */
package smc_pkg;

    // ####################
    // Datapath widths
    // ####################

    localparam int param_w   = 3;
    localparam int mode_w    = 2;
    localparam int dev_val_w = 8;
    localparam int third_w   = 7;
    localparam int result_w  = 8;

    localparam int num_dev = 6;
    localparam int vth     = 1;

    typedef logic [param_w-1:0]   param_t;
    typedef logic [mode_w-1:0]    mode_t;
    typedef logic [dev_val_w-1:0] dev_val_t;
    typedef logic [third_w-1:0]   third_t;
    typedef logic [result_w-1:0]  result_t;

    // ####################
    // APB
    // ####################

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    typedef logic [apb_addr_w-1:0] apb_addr_t;
    typedef logic [apb_data_w-1:0] apb_data_t;

    // Register offsets
    localparam apb_addr_t ctrl_addr     = 8'h00;
    localparam apb_addr_t dev_base_addr = 8'h04;
    localparam int        dev_stride    = 4;
    localparam apb_addr_t status_addr   = 8'h20;
    localparam apb_addr_t result_addr   = 8'h24;

    // Control fields, start is write only
    localparam int ctrl_mode_lsb  = 0;
    localparam int ctrl_start_bit = 8;

    // Transistor fields
    localparam int dev_w_lsb   = 0;
    localparam int dev_vgs_lsb = 4;
    localparam int dev_vds_lsb = 8;

    // Status fields
    localparam int status_done_bit = 0;

endpackage

// File: hdl/smc_top.sv
/*
 * Register block in front of a three-stage pipeline, launch to result in 3 cycles.
 * Mode is captured per stage, so back-to-back launches keep their own mode.
 */
module smc_top (
    input  logic               clk,
    input  logic               rst,
    input  smc_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  smc_pkg::apb_data_t pwdata,
    output smc_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr
);

    smc_pkg::param_t             w       [smc_pkg::num_dev];
    smc_pkg::param_t             vgs     [smc_pkg::num_dev];
    smc_pkg::param_t             vds     [smc_pkg::num_dev];
    smc_pkg::dev_val_t           dev_val [smc_pkg::num_dev];
    logic [smc_pkg::num_dev-1:0] eval_valid;
    smc_pkg::mode_t              mode;
    logic                        launch;
    logic                        sel_in_valid;
    logic                        sel_valid;
    smc_pkg::dev_val_t           hi;
    smc_pkg::dev_val_t           mid;
    smc_pkg::dev_val_t           lo;
    logic                        res_valid;
    smc_pkg::result_t            result;
    logic                        pick_largest_s1;
    logic                        current_mode_s1;
    logic                        current_mode_s2;

    smc_apb_regs u_smc_apb_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .w         (w),
        .vgs       (vgs),
        .vds       (vds),
        .mode      (mode),
        .launch    (launch),
        .res_valid (res_valid),
        .result    (result)
    );

    // ####################
    // Stage 1
    // ####################

    for (genvar i = 0; i < smc_pkg::num_dev; i++) begin : g_dev
        mosfet_eval u_mosfet_eval (
            .clk          (clk),
            .rst          (rst),
            .in_valid     (launch),
            .w            (w[i]),
            .vgs          (vgs[i]),
            .vds          (vds[i]),
            .current_mode (mode[0]),
            .out_valid    (eval_valid[i]),
            .value        (dev_val[i])
        );
    end

    // Mode travels with the data
    always_ff @(posedge clk) begin
        if (launch) begin
            pick_largest_s1 <= mode[1];
            current_mode_s1 <= mode[0];
        end
        if (sel_in_valid) begin
            current_mode_s2 <= current_mode_s1;
        end
    end

    assign sel_in_valid = &eval_valid;

    // ####################
    // Stages 2 and 3
    // ####################

    top3_select u_top3_select (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (sel_in_valid),
        .pick_largest (pick_largest_s1),
        .vals         (dev_val),
        .out_valid    (sel_valid),
        .hi           (hi),
        .mid          (mid),
        .lo           (lo)
    );

    result_combine u_result_combine (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (sel_valid),
        .current_mode (current_mode_s2),
        .hi           (hi),
        .mid          (mid),
        .lo           (lo),
        .res_valid    (res_valid),
        .result       (result)
    );

endmodule

// File: hdl/top3_select.sv
/*
 * Picks the three largest or three smallest of six values, sorted.
 * Smallest mode runs the same network on inverted values.
 */
module top3_select (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic              pick_largest,
    input  smc_pkg::dev_val_t vals [smc_pkg::num_dev],
    output logic              out_valid,
    output smc_pkg::dev_val_t hi,
    output smc_pkg::dev_val_t mid,
    output smc_pkg::dev_val_t lo
);

    smc_pkg::dev_val_t x       [smc_pkg::num_dev];
    smc_pkg::dev_val_t pair_hi [3];
    smc_pkg::dev_val_t pair_lo [3];
    smc_pkg::dev_val_t t1;
    smc_pkg::dev_val_t t2;
    smc_pkg::dev_val_t t3;
    smc_pkg::dev_val_t t2_a;
    smc_pkg::dev_val_t t2_b;
    smc_pkg::dev_val_t m_hi;
    smc_pkg::dev_val_t m_mid;
    smc_pkg::dev_val_t m_lo;

    // Compare and swap, larger first
    function automatic logic [2*smc_pkg::dev_val_w-1:0] sort2(
        input smc_pkg::dev_val_t a,
        input smc_pkg::dev_val_t b
    );
        return (a >= b) ? {a, b} : {b, a};
    endfunction

    always_comb begin
        for (int i = 0; i < smc_pkg::num_dev; i++) begin
            x[i] = pick_largest ? vals[i] : ~vals[i];
        end
        for (int p = 0; p < 3; p++) begin
            {pair_hi[p], pair_lo[p]} = sort2(x[2*p], x[2*p+1]);
        end

        // Top three of the first four, the overall minimum drops out
        {t1, t2_a} = sort2(pair_hi[0], pair_hi[1]);
        t2_b       = (pair_lo[0] >= pair_lo[1]) ? pair_lo[0] : pair_lo[1];
        {t2, t3}   = sort2(t2_a, t2_b);

        // Merge in the last pair
        if (pair_hi[2] >= t1) begin
            m_hi = pair_hi[2];
            if (pair_lo[2] >= t1) begin
                m_mid = pair_lo[2];
                m_lo  = t1;
            end else begin
                m_mid = t1;
                m_lo  = (pair_lo[2] >= t2) ? pair_lo[2] : t2;
            end
        end else if (pair_hi[2] >= t2) begin
            m_hi  = t1;
            m_mid = pair_hi[2];
            m_lo  = (pair_lo[2] >= t2) ? pair_lo[2] : t2;
        end else begin
            m_hi  = t1;
            m_mid = t2;
            m_lo  = (pair_hi[2] >= t3) ? pair_hi[2] : t3;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Inversion flips the order back
    always_ff @(posedge clk) begin
        if (in_valid) begin
            hi  <= pick_largest ? m_hi  : ~m_lo;
            mid <= pick_largest ? m_mid : ~m_mid;
            lo  <= pick_largest ? m_lo  : ~m_hi;
        end
    end

    a_sorted_out: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> (hi >= mid) && (mid >= lo)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_smc -Mdir obj_dir -o tb_smc_sim && \
./obj_dir/tb_smc_sim || exit 1

// File: sim.f
+incdir+tests
hdl/smc_pkg.sv
hdl/mosfet_eval.sv
hdl/top3_select.sv
hdl/result_combine.sv
hdl/smc_apb_regs.sv
hdl/smc_top.sv
tests/tb_smc.sv

// File: tests/smc_ref_model.svh
/*
 * Reference model of the calculator, built from the device and selection rules.
 * Plain integer arithmetic. Included inside the testbench module.
 */
`ifndef smc_ref_model_svh
`define smc_ref_model_svh

// One device, current or transconductance times W
function automatic int dev_value(input int w, input int vgs, input int vds, input bit current);
    int vov;
    vov = vgs - smc_pkg::vth;
    if (vov < 0) begin
        vov = 0;
    end
    if (!current) begin
        return w * 2 * ((vov < vds) ? vov : vds);
    end
    if (vov > vds) begin
        return w * vds * (2 * vov - vds);
    end
    return w * vov * vov;
endfunction

function automatic int model_result(
    input int w   [smc_pkg::num_dev],
    input int vgs [smc_pkg::num_dev],
    input int vds [smc_pkg::num_dev],
    input int mode
);
    int v [smc_pkg::num_dev];
    int tmp;
    int base;
    int n_hi;
    int n_mid;
    int n_lo;
    bit current;
    bit largest;
    current = (mode % 2) == 1;
    largest = ((mode / 2) % 2) == 1;
    for (int i = 0; i < smc_pkg::num_dev; i++) begin
        v[i] = dev_value(w[i], vgs[i], vds[i], current);
    end
    // Descending order
    for (int i = 0; i < smc_pkg::num_dev - 1; i++) begin
        for (int j = 0; j < smc_pkg::num_dev - 1 - i; j++) begin
            if (v[j] < v[j+1]) begin
                tmp    = v[j];
                v[j]   = v[j+1];
                v[j+1] = tmp;
            end
        end
    end
    base  = largest ? 0 : smc_pkg::num_dev - 3;
    n_hi  = v[base] / 3;
    n_mid = v[base+1] / 3;
    n_lo  = v[base+2] / 3;
    if (current) begin
        return ((3 * n_hi + 5 * n_lo) / 4 + n_mid) / 3;
    end
    return (n_hi + n_mid + n_lo) / 3;
endfunction

`endif

// File: tests/tb_smc.sv
/*
 * Random and directed testbench for smc_top over APB with a fixed seed.
 * Stops at the first mismatch. Every done wait is bounded in cycles.
 */
module tb_smc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_random   = 200;
    localparam int done_timeout = 50;
    localparam smc_pkg::apb_addr_t unmapped_addr [5] = '{8'h02, 8'h1c, 8'h28, 8'h80, 8'hfc};

    logic               clk;
    logic               rst;
    smc_pkg::apb_addr_t paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    smc_pkg::apb_data_t pwdata;
    smc_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;

    int cycle_count;
    int cfg_w   [smc_pkg::num_dev];
    int cfg_vgs [smc_pkg::num_dev];
    int cfg_vds [smc_pkg::num_dev];

    `include "smc_ref_model.svh"

    smc_top u_smc_top (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ####################
    // Helpers
    // ####################

    task automatic fail_run(input string why);
        $display("STATUS: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %.1f ns: %s, got 0x%0h, expected 0x%0h",
                     $realtime, what, got, exp);
            fail_run("Value mismatch, run stopped");
        end
    endtask

    function automatic bit is_mapped(input smc_pkg::apb_addr_t addr);
        int off;
        off = int'(addr) - int'(smc_pkg::dev_base_addr);
        if (addr == smc_pkg::ctrl_addr || addr == smc_pkg::status_addr
            || addr == smc_pkg::result_addr) begin
            return 1'b1;
        end
        return (off >= 0) && (off < smc_pkg::num_dev * smc_pkg::dev_stride)
               && (off % smc_pkg::dev_stride == 0);
    endfunction

    function automatic smc_pkg::apb_addr_t dev_addr(input int i);
        return smc_pkg::apb_addr_t'(smc_pkg::dev_base_addr + i * smc_pkg::dev_stride);
    endfunction

    function automatic logic [31:0] dev_word(input int w, input int vgs, input int vds);
        logic [31:0] d;
        d = '0;
        d[smc_pkg::dev_w_lsb +: smc_pkg::param_w]   = smc_pkg::param_t'(w);
        d[smc_pkg::dev_vgs_lsb +: smc_pkg::param_w] = smc_pkg::param_t'(vgs);
        d[smc_pkg::dev_vds_lsb +: smc_pkg::param_w] = smc_pkg::param_t'(vds);
        return d;
    endfunction

    function automatic logic [31:0] ctrl_word(input int mode, input bit start);
        logic [31:0] d;
        d = '0;
        d[smc_pkg::ctrl_mode_lsb +: smc_pkg::mode_w] = smc_pkg::mode_t'(mode);
        d[smc_pkg::ctrl_start_bit] = start;
        return d;
    endfunction

    // Setup phase followed by access phase
    // pslverr is expected only on unmapped offsets
    task automatic apb_transfer(
        input  smc_pkg::apb_addr_t addr,
        input  logic               write,
        input  smc_pkg::apb_data_t wdata,
        output smc_pkg::apb_data_t rdata
    );
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #3;
        rdata = prdata;
        check_eq(32'(pready), 32'd1, "pready in access phase");
        check_eq(32'(pslverr), 32'(!is_mapped(addr)), $sformatf("pslverr at 0x%02h", addr));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input smc_pkg::apb_addr_t addr, input smc_pkg::apb_data_t data);
        smc_pkg::apb_data_t unused;
        apb_transfer(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(input smc_pkg::apb_addr_t addr, output smc_pkg::apb_data_t data);
        apb_transfer(addr, 1'b0, '0, data);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          start;
        start = cycle_count;
        st    = '0;
        while (st[smc_pkg::status_done_bit] !== 1'b1) begin
            if (cycle_count - start > done_timeout) begin
                fail_run("Timed out waiting for the done flag after a start");
            end
            apb_read(smc_pkg::status_addr, st);
        end
    endtask

    task automatic randomize_devices();
        for (int i = 0; i < smc_pkg::num_dev; i++) begin
            cfg_w[i]   = $urandom_range(7, 0);
            cfg_vgs[i] = $urandom_range(7, 0);
            cfg_vds[i] = $urandom_range(7, 0);
        end
    endtask

    // Loads the config and starts a run that must clear done before the result is read
    task automatic run_eval(input int mode);
        logic [31:0] rd;
        int          expected;
        for (int i = 0; i < smc_pkg::num_dev; i++) begin
            apb_write(dev_addr(i), dev_word(cfg_w[i], cfg_vgs[i], cfg_vds[i]));
        end
        apb_write(smc_pkg::ctrl_addr, ctrl_word(mode, 1'b1));
        apb_read(smc_pkg::status_addr, rd);
        check_eq(32'(rd[smc_pkg::status_done_bit]), 32'd0, "done right after start");
        wait_done();
        expected = model_result(cfg_w, cfg_vgs, cfg_vds, mode);
        apb_read(smc_pkg::result_addr, rd);
        check_eq(rd, 32'(expected), $sformatf("result in mode %0d", mode));
    endtask

    // ####################
    // Test sequence
    // ####################

    initial begin
        logic [31:0] rd;
        logic [31:0] exp_word;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(32'h45eaa3aa));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        apb_read(smc_pkg::status_addr, rd);
        check_eq(rd, 32'd0, "status after reset");
        apb_read(smc_pkg::result_addr, rd);
        check_eq(rd, 32'd0, "result after reset");
        apb_read(smc_pkg::ctrl_addr, rd);
        check_eq(rd, 32'd0, "ctrl after reset");

        // Register readback
        for (int r = 0; r < 3; r++) begin
            randomize_devices();
            for (int i = 0; i < smc_pkg::num_dev; i++) begin
                exp_word = dev_word(cfg_w[i], cfg_vgs[i], cfg_vds[i]);
                apb_write(dev_addr(i), exp_word);
                apb_read(dev_addr(i), rd);
                check_eq(rd & dev_word(7, 7, 7), exp_word, $sformatf("device %0d readback", i));
            end
        end
        for (int m = 0; m < 4; m++) begin
            apb_write(smc_pkg::ctrl_addr, ctrl_word(m, 1'b0));
            apb_read(smc_pkg::ctrl_addr, rd);
            check_eq(rd & ctrl_word(3, 1'b1), ctrl_word(m, 1'b0), "mode readback");
        end

        for (int n = 0; n < num_random; n++) begin
            randomize_devices();
            run_eval(n % 4);
        end
        apb_read(smc_pkg::ctrl_addr, rd);
        check_eq(32'(rd[smc_pkg::ctrl_start_bit]), 32'd0, "start bit readback");

        // Nothing conducts below threshold
        for (int m = 0; m < 4; m++) begin
            randomize_devices();
            for (int i = 0; i < smc_pkg::num_dev; i++) begin
                cfg_vgs[i] = $urandom_range(1, 0);
            end
            run_eval(m);
            apb_read(smc_pkg::result_addr, rd);
            check_eq(rd, 32'd0, "result below threshold");
        end

        for (int i = 0; i < smc_pkg::num_dev; i++) begin
            cfg_w[i]   = 7;
            cfg_vgs[i] = 7;
            cfg_vds[i] = 7;
        end
        run_eval(3);

        // Vov equal to Vds sits on the saturation side
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < smc_pkg::num_dev; i++) begin
                cfg_w[i]   = $urandom_range(7, 0);
                cfg_vds[i] = $urandom_range(6, 0);
                cfg_vgs[i] = cfg_vds[i] + 1;
            end
            run_eval(m);
        end

        for (int k = 0; k < 5; k++) begin
            apb_read(unmapped_addr[k], rd);
            apb_write(unmapped_addr[k], 32'hffff_ffff);
        end

        // done is still set from the last run and must clear and set again
        apb_read(smc_pkg::status_addr, rd);
        check_eq(32'(rd[smc_pkg::status_done_bit]), 32'd1, "done before restart");
        randomize_devices();
        run_eval(2);

        $display("STATUS: PASS");
        $finish;
    end

endmodule
